//--- src.f
design/sdspi_pkg.sv
design/sdspi_clkgen.sv
design/sdspi_shifter.sv
design/sdspi_wb_regs.sv
design/sdspi.sv
test/tb_sdspi.sv

//--- test/tb_sdspi.sv
// SD card SPI master testbench
`timescale 1ns/1ps

module tb_sdspi
  import sdspi_pkg::*;
();

  localparam time CLK_PERIOD  = 40ns;
  localparam time DRV_DELAY   = 2ns;   // Inputs change shortly after the edge
  localparam int  RST_CYCLES  = 5;
  localparam logic [31:0] SEED = 32'he820;
  localparam int  XFER_BITS   = 8;
  localparam int  N_RAND_WR   = 6;
  localparam int  N_READS     = 4;
  // Six command bytes, random writes, reads, two combined and two held transfers
  localparam int  N_XFERS        = 6 + N_RAND_WR + N_READS + 4;
  localparam int  TIMEOUT_CYCLES = N_XFERS * 40 + 200;

  logic              clk;
  logic              rst;
  logic [BUS_W-1:0]  wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_we;
  logic [1:0]        wb_sel;
  logic              wb_stb;
  logic              wb_cyc;
  logic              wb_ack;
  logic              sclk;
  logic              mosi;
  logic              ss;
  logic              miso;

  // Card model state
  logic [7:0]  card_tx;
  logic [7:0]  card_rx;
  int          rise_cnt;
  logic        first_rise_seen;
  logic        ss_first_rise;

  // Bus and run bookkeeping
  logic [31:0] lfsr;
  int          cycle_cnt;
  int          wait_cycles;
  int          xfer_rises;
  logic [7:0]  ack_data;
  logic [7:0]  last_rx;
  logic        ss_expect;
  logic [7:0]  cmd_bytes [0:5];

  sdspi sdspi_i (
    .clk    (clk),
    .rst    (rst),
    .dat_i  (wb_dat_w),
    .dat_o  (wb_dat_r),
    .we_i   (wb_we),
    .sel_i  (wb_sel),
    .stb_i  (wb_stb),
    .cyc_i  (wb_cyc),
    .ack_o  (wb_ack),
    .sclk_o (sclk),
    .mosi_o (mosi),
    .ss_o   (ss),
    .miso_i (miso)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Card drives the reply MSB first and the line floats high while deselected
  assign miso = ss ? 1'b1 : card_tx[7];

  always @(negedge sclk) begin
    card_tx <= {card_tx[6:0], 1'b1};
  end

  always @(posedge sclk) begin
    card_rx  <= {card_rx[6:0], mosi};
    rise_cnt <= rise_cnt + 1;
    if (!first_rise_seen) begin
      ss_first_rise   <= ss;
      first_rise_seen <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the DUT stopped answering bus requests");
      $display("Simulation failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // Taps 32, 22, 2, 1
    return {s[30:0], fb};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else
      report_failure($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
  endtask

  // One Wishbone request held until ack
  task automatic bus_request(input logic we, input logic [1:0] sel,
                             input logic [BUS_W-1:0] data, input logic [7:0] reply,
                             input logic hold);
    int rises_at_start;
    @(posedge clk);
    #DRV_DELAY;
    card_tx         = reply;
    first_rise_seen = 1'b0;
    rises_at_start  = rise_cnt;
    wait_cycles     = 0;
    wb_dat_w = data;
    wb_we    = we;
    wb_sel   = sel;
    wb_stb   = 1'b1;
    wb_cyc   = 1'b1;
    do begin
      @(posedge clk);
      #DRV_DELAY;
      wait_cycles++;
    end while (!wb_ack);
    ack_data   = wb_dat_r;
    xfer_rises = rise_cnt - rises_at_start;
    if (hold) begin
      @(posedge clk);
      #DRV_DELAY;
      expect_equal("ack_o one cycle after ack", wb_ack, 0);
      @(posedge clk);  // Master still holding stb here
      #DRV_DELAY;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
    end else begin
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      @(posedge clk);
      #DRV_DELAY;
      expect_equal("ack_o one cycle after ack", wb_ack, 0);
    end
  endtask

  task automatic verify_transfer(input logic [7:0] exp_mosi, input logic [7:0] exp_miso);
    expect_equal("sclk rising edges before ack", xfer_rises, XFER_BITS);
    expect_equal("byte seen by card", card_rx, exp_mosi);
    expect_equal("dat_o at ack", ack_data, exp_miso);
    last_rx = exp_miso;
  endtask

  task automatic watch_idle(input int cycles);
    int rises_at_start;
    rises_at_start = rise_cnt;
    repeat (cycles) begin
      @(posedge clk);
      #DRV_DELAY;
      expect_equal("ack_o while idle", wb_ack, 0);
      expect_equal("sclk_o while idle", sclk, 0);
    end
    expect_equal("sclk edges while idle", rise_cnt - rises_at_start, 0);
  endtask

  task automatic set_chip_select(input logic level);
    bus_request(1'b1, 2'b10, {level, 8'h5A}, 8'hFF, 1'b0);
    ss_expect = level;
    expect_equal("ss_o after select write", ss, level);
    expect_equal("ack latency of select write", wait_cycles, 1);
    watch_idle(2 * SCLK_HALF);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic hold);
    logic [7:0] reply;
    reply = rand_byte();
    bus_request(1'b1, 2'b01, {~ss_expect, b}, reply, hold);  // Bit 8 must be ignored
    expect_equal("ss_o after byte write", ss, ss_expect);
    verify_transfer(b, ss_expect ? 8'hFF : reply);
  endtask

  task automatic fetch_byte();
    logic [7:0] reply;
    reply = rand_byte();
    bus_request(1'b0, 2'b01, '0, reply, 1'b0);
    verify_transfer(8'hFF, ss_expect ? 8'hFF : reply);
  endtask

  task automatic select_and_send(input logic level, input logic [7:0] b);
    logic [7:0] reply;
    reply = rand_byte();
    bus_request(1'b1, 2'b11, {level, b}, reply, 1'b0);
    ss_expect = level;
    expect_equal("ss_o after combined write", ss, level);
    expect_equal("ss_o at first sclk edge", ss_first_rise, level);
    verify_transfer(b, level ? 8'hFF : reply);
  endtask

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    wb_dat_w        = '0;
    wb_we           = 1'b0;
    wb_sel          = 2'b00;
    wb_stb          = 1'b0;
    wb_cyc          = 1'b0;
    card_tx         = 8'hFF;
    card_rx         = 8'h00;
    rise_cnt        = 0;
    first_rise_seen = 1'b0;
    ss_first_rise   = 1'b1;
    lfsr            = SEED;
    cycle_cnt       = 0;
    last_rx         = 8'h00;
    ss_expect       = 1'b1;
    cmd_bytes       = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};  // CMD0

    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DELAY;
    rst = 1'b0;
    @(posedge clk);
    #DRV_DELAY;

    // Idle levels after reset
    expect_equal("ss_o after reset", ss, 1);
    expect_equal("sclk_o after reset", sclk, 0);
    expect_equal("ack_o after reset", wb_ack, 0);
    expect_equal("mosi_o after reset", mosi, 1);
    expect_equal("dat_o after reset", wb_dat_r, 0);

    set_chip_select(1'b0);
    set_chip_select(1'b1);
    set_chip_select(1'b0);

    foreach (cmd_bytes[i]) send_byte(cmd_bytes[i], 1'b0);
    repeat (N_RAND_WR) send_byte(rand_byte(), 1'b0);
    repeat (N_READS) fetch_byte();

    // Deselect and select again together with a byte each
    select_and_send(1'b1, rand_byte());
    select_and_send(1'b0, rand_byte());

    // Master keeps stb up past the ack
    send_byte(rand_byte(), 1'b1);
    watch_idle(4 * SCLK_HALF * 2);
    send_byte(rand_byte(), 1'b1);
    watch_idle(4 * SCLK_HALF * 2);

    // Request without sel bit changes nothing
    bus_request(1'b1, 2'b00, {~ss_expect, 8'hC3}, rand_byte(), 1'b0);
    expect_equal("ack latency without sel", wait_cycles, 1);
    expect_equal("ss_o without sel", ss, ss_expect);
    expect_equal("dat_o without sel", wb_dat_r, last_rx);
    watch_idle(2 * SCLK_HALF);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- design/sdspi.sv
// SD card SPI master with Wishbone port
`timescale 1ns/1ps

module sdspi
  import sdspi_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  // Wishbone slave
  input  logic [BUS_W-1:0]  dat_i,
  output logic [DATA_W-1:0] dat_o,
  input  logic              we_i,
  input  logic [1:0]        sel_i,
  input  logic              stb_i,
  input  logic              cyc_i,
  output logic              ack_o,

  // Serial pads
  output logic              sclk_o,
  output logic              mosi_o,
  output logic              ss_o,
  input  logic              miso_i
);

  logic              busy;
  logic              xfer_start;
  logic [DATA_W-1:0] tx_byte;
  logic              sclk_rise;
  logic              sclk_fall;
  logic              done;
  logic [DATA_W-1:0] rx_byte;

  sdspi_wb_regs regs_i (
    .clk       (clk),
    .rst       (rst),
    .dat_i     (dat_i),
    .we_i      (we_i),
    .sel_i     (sel_i),
    .stb_i     (stb_i),
    .cyc_i     (cyc_i),
    .dat_o     (dat_o),
    .ack_o     (ack_o),
    .ss_o      (ss_o),
    .start_o   (xfer_start),
    .tx_byte_o (tx_byte),
    .busy_o    (busy),
    .done_i    (done),
    .rx_byte_i (rx_byte)
  );

  // sclk runs only while busy
  sdspi_clkgen clkgen_i (
    .clk    (clk),
    .rst    (rst),
    .busy_i (busy),
    .sclk_o (sclk_o),
    .rise_o (sclk_rise),
    .fall_o (sclk_fall)
  );

  sdspi_shifter shifter_i (
    .clk       (clk),
    .rst       (rst),
    .start_i   (xfer_start),
    .tx_byte_i (tx_byte),
    .rise_i    (sclk_rise),
    .fall_i    (sclk_fall),
    .miso_i    (miso_i),
    .mosi_o    (mosi_o),
    .done_o    (done),
    .rx_byte_o (rx_byte)
  );

endmodule

//--- design/sdspi_wb_regs.sv
// Wishbone slave registers for the SPI master
`timescale 1ns/1ps

module sdspi_wb_regs
  import sdspi_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [BUS_W-1:0]  dat_i,
  input  logic              we_i,
  input  logic [1:0]        sel_i,
  input  logic              stb_i,
  input  logic              cyc_i,
  output logic [DATA_W-1:0] dat_o,
  output logic              ack_o,
  output logic              ss_o,
  output logic              start_o,
  output logic [DATA_W-1:0] tx_byte_o,
  output logic              busy_o,
  input  logic              done_i,
  input  logic [DATA_W-1:0] rx_byte_i
);

  logic              ack_q;
  logic              ack_d;   // Ack delayed by one cycle
  logic              busy_q;
  logic              start_q;
  logic              ss_q;
  logic [DATA_W-1:0] rx_q;
  logic [DATA_W-1:0] tx_q;
  logic              req;

  // New request, masked while a transfer runs and around an ack
  // so that a master still holding stb does not start twice
  assign req = stb_i & cyc_i & ~busy_q & ~ack_q & ~ack_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q   <= 1'b0;
      ack_d   <= 1'b0;
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      ss_q    <= SS_IDLE;
      rx_q    <= '0;
    end else begin
      ack_d   <= ack_q;
      ack_q   <= 1'b0;
      start_q <= 1'b0;

      if (req) begin
        if (sel_i[1] && we_i) begin
          ss_q <= dat_i[BUS_W-1];  // Chip select bit
        end
        if (sel_i[0]) begin
          busy_q  <= 1'b1;  // Ack waits for the shifter
          start_q <= 1'b1;
        end else begin
          ack_q <= 1'b1;
        end
      end

      if (done_i && busy_q) begin
        rx_q   <= rx_byte_i;
        ack_q  <= 1'b1;
        busy_q <= 1'b0;
      end
    end
  end

  // Byte to send, a read clocks out the idle pattern
  always_ff @(posedge clk) begin
    if (req && sel_i[0]) begin
      tx_q <= we_i ? dat_i[DATA_W-1:0] : TX_IDLE;
    end
  end

  assign dat_o     = rx_q;
  assign ack_o     = ack_q;
  assign ss_o      = ss_q;
  assign start_o   = start_q;
  assign tx_byte_o = tx_q;
  assign busy_o    = busy_q;

endmodule

//--- design/sdspi_shifter.sv
// SPI byte shift register
`timescale 1ns/1ps

module sdspi_shifter
  import sdspi_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start_i,
  input  logic [DATA_W-1:0] tx_byte_i,
  input  logic              rise_i,
  input  logic              fall_i,
  input  logic              miso_i,
  output logic              mosi_o,
  output logic              done_o,
  output logic [DATA_W-1:0] rx_byte_o
);

  logic [DATA_W-1:0]    tx_sr;   // Bits still to go out with the next one at the top
  logic [DATA_W-1:0]    rx_sr;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 active;
  logic                 mosi_q;
  logic                 last_bit;

  assign last_bit = (bit_cnt == BIT_CNT_W'(BITS_PER_XFER - 1));

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      active  <= 1'b0;
      bit_cnt <= '0;
      mosi_q  <= MOSI_IDLE;
    end else if (start_i) begin
      active  <= 1'b1;
      bit_cnt <= '0;
      mosi_q  <= tx_byte_i[DATA_W-1];  // MSB first
    end else if (active) begin
      if (rise_i) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (last_bit) begin
          active <= 1'b0;
          mosi_q <= MOSI_IDLE;
        end
      end else if (fall_i) begin
        mosi_q <= tx_sr[DATA_W-1];
      end
    end
  end

  // Shift registers
  always_ff @(posedge clk) begin
    if (start_i) begin
      tx_sr <= {tx_byte_i[DATA_W-2:0], MOSI_IDLE};
    end else if (active && fall_i) begin
      tx_sr <= {tx_sr[DATA_W-2:0], MOSI_IDLE};
    end

    if (active && rise_i) begin
      rx_sr <= {rx_sr[DATA_W-2:0], miso_i};  // Sample on rising edge
    end
  end

  assign mosi_o = mosi_q;

  // Done on the eighth rising edge with the last bit taken straight from the pad
  assign done_o    = active & rise_i & last_bit;
  assign rx_byte_o = {rx_sr[DATA_W-2:0], miso_i};

endmodule

//--- design/sdspi_clkgen.sv
// SPI serial clock generator
`timescale 1ns/1ps

module sdspi_clkgen
  import sdspi_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic busy_i,
  output logic sclk_o,
  output logic rise_o,
  output logic fall_o
);

  logic [HALF_CNT_W-1:0] half_cnt;
  logic                  sclk_q;
  logic                  rise_q;
  logic                  fall_q;
  logic                  half_done;

  // Last system clock of the current sclk half period
  assign half_done = (half_cnt == HALF_CNT_W'(SCLK_HALF - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      half_cnt <= '0;
      sclk_q   <= 1'b0;
      rise_q   <= 1'b0;
      fall_q   <= 1'b0;
    end else if (!busy_i) begin
      // Idle, mode 0 keeps sclk low
      half_cnt <= '0;
      sclk_q   <= 1'b0;
      rise_q   <= 1'b0;
      fall_q   <= 1'b0;
    end else begin
      rise_q <= 1'b0;
      fall_q <= 1'b0;
      if (half_done) begin
        half_cnt <= '0;
        sclk_q   <= ~sclk_q;
        rise_q   <= ~sclk_q;  // Low going high
        fall_q   <= sclk_q;   // High going low
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // Strobes line up with the cycle in which sclk has just changed
  assign sclk_o = sclk_q;
  assign rise_o = rise_q;
  assign fall_o = fall_q;

endmodule

//--- design/sdspi_pkg.sv
// SD card SPI master constants
package sdspi_pkg;

  // Serial byte and Wishbone widths
  localparam int DATA_W = 8;
  localparam int BUS_W  = DATA_W + 1;  // Data byte plus ss bit

  // System clocks per sclk half period, so one bit takes 2*SCLK_HALF clocks
  localparam int SCLK_HALF = 2;

  localparam int BITS_PER_XFER = 8;  // Mode 0, MSB first

  // Counter widths derived from the above
  localparam int HALF_CNT_W = $clog2(SCLK_HALF + 1);
  localparam int BIT_CNT_W  = $clog2(BITS_PER_XFER);

  // Idle levels on the pads
  localparam logic SS_IDLE   = 1'b1;  // Card deselected
  localparam logic MOSI_IDLE = 1'b1;

  // Byte sent out while reading
  localparam logic [DATA_W-1:0] TX_IDLE = 8'hFF;

endpackage
